/* rtl/cpu_ctrl_pkg.sv */
package cpu_ctrl_pkg;

    typedef logic [4:0]  reg_idx_t;                     // architectural register index
    typedef logic [31:0] pc_t;                          // program counter / instruction address

    typedef enum logic [1:0] {
        NORMAL = 2'b00,                                 // stage advances
        HOLD   = 2'b01,                                 // stage keeps its contents
        NO_OP  = 2'b10                                  // stage loads a bubble
    } stage_ctrl_t;

    typedef enum logic [2:0] {
        NONE   = 3'd0,                                  // pipeline running freely
        DATA   = 3'd1,                                  // load-use or branch operand conflict
        UART   = 3'd2,                                  // pc ran off the program, wait for rewrite
        PAUSE  = 3'd3,                                  // user pause, rewrite allowed meanwhile
        KEYPAD = 3'd4                                   // instruction waits for keypad input
    } issue_t;

    typedef enum logic [1:0] {
        IDLE      = 2'd0,                               // first cycle out of reset
        EXECUTE   = 2'd1,                               // watching for new issues
        HAZARD    = 2'd2,                               // data, uart or pause pending
        INTERRUPT = 2'd3                                // keypad freeze
    } cpu_state_t;

    localparam pc_t PC_MAX_VALUE = 32'd15;              // last address holding an instruction
    localparam int  STAGE_CNT    = 5;                   // one command per stage register

    localparam int IF_STAGE  = 0;                       // index into the command array
    localparam int ID_STAGE  = 1;
    localparam int EX_STAGE  = 2;
    localparam int MEM_STAGE = 3;
    localparam int WB_STAGE  = 4;

endpackage

/* rtl/fetch_unit.sv */
`timescale 1ns/10ps

module fetch_unit (
    input  logic                      clk,
    input  logic                      rst_n,
    input  cpu_ctrl_pkg::stage_ctrl_t if_ctrl,            // steers the pc
    input  cpu_ctrl_pkg::stage_ctrl_t id_ctrl,            // steers the IF/ID register
    input  logic                      pc_reset,           // restart the program at address 0
    input  logic                      instr_reg_1_valid,
    input  logic                      instr_reg_2_valid,
    input  cpu_ctrl_pkg::reg_idx_t    instr_reg_1_idx,
    input  cpu_ctrl_pkg::reg_idx_t    instr_reg_2_idx,
    input  cpu_ctrl_pkg::reg_idx_t    instr_dest_idx,
    input  logic                      instr_reg_write,
    input  logic                      instr_mem_read,
    input  logic                      instr_branch,
    input  logic                      instr_input_req,
    output cpu_ctrl_pkg::pc_t         pc,
    output logic                      pc_overflow,        // pc points past the program
    output logic                      id_reg_1_valid,
    output logic                      id_reg_2_valid,
    output cpu_ctrl_pkg::reg_idx_t    id_reg_1_idx,
    output cpu_ctrl_pkg::reg_idx_t    id_reg_2_idx,
    output cpu_ctrl_pkg::reg_idx_t    id_dest_idx,
    output logic                      id_reg_write,
    output logic                      id_mem_read,
    output logic                      id_branch,
    output logic                      id_input_req,
    output logic                      id_no_op            // ID holds a bubble
);
    import cpu_ctrl_pkg::*;

    logic load_instr;                                     // IF/ID takes a real instruction

    assign pc_overflow = pc > PC_MAX_VALUE;               // the address about to be fetched is empty
    assign load_instr  = (id_ctrl == NORMAL) && (if_ctrl == NORMAL) && !pc_reset;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pc <= '0;
        end else if (pc_reset) begin
            pc <= '0;                                     // resume after uart rewrite or pause
        end else if (if_ctrl == NORMAL) begin
            pc <= pc + pc_t'(1);                          // HOLD and NO_OP keep the address
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            id_no_op       <= 1'b1;                       // start out empty
            id_reg_1_valid <= 1'b0;
            id_reg_2_valid <= 1'b0;
            id_reg_write   <= 1'b0;
            id_mem_read    <= 1'b0;
            id_branch      <= 1'b0;
            id_input_req   <= 1'b0;
        end else if (id_ctrl != HOLD) begin
            id_no_op       <= !load_instr;                // bubble unless fetch offers one
            id_reg_1_valid <= load_instr && instr_reg_1_valid;
            id_reg_2_valid <= load_instr && instr_reg_2_valid;
            id_reg_write   <= load_instr && instr_reg_write;
            id_mem_read    <= load_instr && instr_mem_read;
            id_branch      <= load_instr && instr_branch;
            id_input_req   <= load_instr && instr_input_req;
        end
    end

    always_ff @(posedge clk) begin
        if (load_instr) begin
            id_reg_1_idx <= instr_reg_1_idx;              // indices only matter with their enables
            id_reg_2_idx <= instr_reg_2_idx;
            id_dest_idx  <= instr_dest_idx;
        end
    end

endmodule

/* rtl/stage_reg.sv */
`timescale 1ns/10ps

module stage_reg (
    input  logic                      clk,
    input  logic                      rst_n,
    input  cpu_ctrl_pkg::stage_ctrl_t ctrl,               // NORMAL, HOLD or NO_OP
    input  cpu_ctrl_pkg::reg_idx_t    in_dest,
    input  logic                      in_reg_write,
    input  logic                      in_mem_read,
    input  logic                      in_input_req,
    input  logic                      in_no_op,
    output cpu_ctrl_pkg::reg_idx_t    out_dest,
    output logic                      out_reg_write,
    output logic                      out_mem_read,
    output logic                      out_input_req,
    output logic                      out_no_op
);
    import cpu_ctrl_pkg::*;

    logic live;                                           // a real instruction moves in

    assign live = (ctrl == NORMAL) && !in_no_op;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            out_no_op     <= 1'b1;                        // empty stage after reset
            out_reg_write <= 1'b0;
            out_mem_read  <= 1'b0;
            out_input_req <= 1'b0;
        end else if (ctrl != HOLD) begin
            out_no_op     <= !live;                       // NO_OP lands here with enables cleared
            out_reg_write <= live && in_reg_write;
            out_mem_read  <= live && in_mem_read;
            out_input_req <= live && in_input_req;
        end
    end

    always_ff @(posedge clk) begin
        if (live) out_dest <= in_dest;
    end

endmodule

/* rtl/hazard_unit.sv */
`timescale 1ns/10ps

module hazard_unit (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      uart_complete,      // rewrite finished
    input  logic                      cpu_pause,          // user pause level
    input  logic                      input_complete,     // keypad entry done
    input  logic                      id_reg_1_valid,
    input  logic                      id_reg_2_valid,
    input  cpu_ctrl_pkg::reg_idx_t    id_reg_1_idx,
    input  cpu_ctrl_pkg::reg_idx_t    id_reg_2_idx,
    input  logic                      id_branch,
    input  cpu_ctrl_pkg::reg_idx_t    ex_dest_idx,
    input  logic                      ex_reg_write,
    input  logic                      ex_mem_read,
    input  logic                      ex_no_op,
    input  cpu_ctrl_pkg::reg_idx_t    mem_dest_idx,
    input  logic                      mem_reg_write,
    input  logic                      mem_input_req,
    input  logic                      mem_no_op,
    input  logic                      pc_overflow,
    output logic                      uart_disable,       // low while a rewrite may happen
    output logic                      pc_reset,           // one cycle restart strobe
    output cpu_ctrl_pkg::stage_ctrl_t if_ctrl,
    output cpu_ctrl_pkg::stage_ctrl_t id_ctrl,
    output cpu_ctrl_pkg::stage_ctrl_t ex_ctrl,
    output cpu_ctrl_pkg::stage_ctrl_t mem_ctrl,
    output cpu_ctrl_pkg::stage_ctrl_t wb_ctrl,
    output cpu_ctrl_pkg::issue_t      issue_type          // shown on the display
);
    import cpu_ctrl_pkg::*;

    stage_ctrl_t cmd [STAGE_CNT];                         // one command per stage register
    cpu_state_t  cpu_state;

    logic ex_conflict;
    logic mem_conflict;
    logic data_hazard;
    logic keypad_req;
    logic data_resolved;
    logic rewrite_resolved;

    // an ID source reads a register that EX or MEM is still going to write
    assign ex_conflict  = ex_reg_write && !ex_no_op &&
                          ((id_reg_1_valid && id_reg_1_idx == ex_dest_idx) ||
                           (id_reg_2_valid && id_reg_2_idx == ex_dest_idx));
    assign mem_conflict = mem_reg_write && !mem_no_op &&
                          ((id_reg_1_valid && id_reg_1_idx == mem_dest_idx) ||
                           (id_reg_2_valid && id_reg_2_idx == mem_dest_idx));

    assign data_hazard  = (ex_mem_read && ex_conflict) ||          // load-use
                          (id_branch && (ex_conflict || mem_conflict)); // branch resolves in ID
    assign keypad_req   = mem_input_req && !mem_no_op;

    assign data_resolved    = (issue_type == DATA) && !data_hazard;
    assign rewrite_resolved = ((issue_type == UART) && uart_complete) ||
                              ((issue_type == PAUSE) && uart_complete && !cpu_pause);

    assign if_ctrl  = cmd[IF_STAGE];
    assign id_ctrl  = cmd[ID_STAGE];
    assign ex_ctrl  = cmd[EX_STAGE];
    assign mem_ctrl = cmd[MEM_STAGE];
    assign wb_ctrl  = cmd[WB_STAGE];

    // falling edge so each decision is in place before the next load
    always_ff @(negedge clk) begin
        if (!rst_n) begin
            cpu_state    <= IDLE;
            issue_type   <= NONE;
            pc_reset     <= 1'b0;
            uart_disable <= 1'b1;
            for (int i = 0; i < STAGE_CNT; i++) cmd[i] <= NORMAL;
        end else begin
            pc_reset <= 1'b0;                             // strobe lasts a single cycle
            case (cpu_state)
                EXECUTE: begin
                    if (data_hazard) begin
                        issue_type    <= DATA;
                        cpu_state     <= HAZARD;
                        cmd[IF_STAGE] <= HOLD;            // keep the dependent instruction in ID
                        cmd[ID_STAGE] <= HOLD;
                        cmd[EX_STAGE] <= NO_OP;           // producer moves on, bubble behind it
                    end else if (cpu_pause) begin
                        issue_type    <= PAUSE;
                        cpu_state     <= HAZARD;
                        uart_disable  <= 1'b0;
                        cmd[IF_STAGE] <= NO_OP;           // drain what is in flight
                    end else if (pc_overflow) begin
                        issue_type    <= UART;
                        cpu_state     <= HAZARD;
                        uart_disable  <= 1'b0;
                        cmd[IF_STAGE] <= NO_OP;
                    end else if (keypad_req) begin
                        issue_type <= KEYPAD;
                        cpu_state  <= INTERRUPT;
                        for (int i = 0; i < STAGE_CNT; i++) cmd[i] <= HOLD; // freeze all
                    end
                end
                HAZARD: begin
                    if (data_resolved) begin
                        issue_type    <= NONE;
                        cpu_state     <= EXECUTE;
                        cmd[IF_STAGE] <= NORMAL;
                        cmd[ID_STAGE] <= NORMAL;
                        cmd[EX_STAGE] <= NORMAL;
                    end else if (rewrite_resolved) begin
                        issue_type    <= NONE;
                        cpu_state     <= EXECUTE;
                        uart_disable  <= 1'b1;
                        pc_reset      <= 1'b1;            // program restarts at address 0
                        cmd[IF_STAGE] <= NORMAL;
                    end else if (issue_type == UART && cpu_pause) begin
                        issue_type <= PAUSE;              // now also wait for the pause to drop
                    end
                end
                INTERRUPT: begin
                    if (input_complete) begin
                        issue_type <= NONE;
                        cpu_state  <= EXECUTE;
                        for (int i = 0; i < STAGE_CNT; i++) cmd[i] <= NORMAL;
                    end
                end
                default: cpu_state <= EXECUTE;            // IDLE lasts one cycle
            endcase
        end
    end

endmodule

/* rtl/retire_unit.sv */
`timescale 1ns/10ps

module retire_unit (
    input  logic                      clk,
    input  logic                      rst_n,
    input  cpu_ctrl_pkg::stage_ctrl_t wb_ctrl,            // MEM/WB command
    input  cpu_ctrl_pkg::reg_idx_t    wb_dest_idx,
    input  logic                      wb_no_op,
    output logic                      retire_valid,       // one pulse per retired instruction
    output cpu_ctrl_pkg::reg_idx_t    retire_dest,
    output logic [15:0]               retired_count
);
    import cpu_ctrl_pkg::*;

    logic retire_now;                                     // real instruction leaves write-back

    assign retire_now = (wb_ctrl == NORMAL) && !wb_no_op; // held or bubble entries never count

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            retire_valid  <= 1'b0;
            retired_count <= '0;
        end else begin
            retire_valid <= retire_now;
            if (retire_now) retired_count <= retired_count + 16'd1; // wraps silently
        end
    end

    always_ff @(posedge clk) begin
        if (retire_now) retire_dest <= wb_dest_idx;       // valid only with retire_valid
    end

endmodule

/* rtl/pipeline_ctrl_top.sv */
`timescale 1ns/10ps

module pipeline_ctrl_top (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   instr_reg_1_valid,
    input  logic                   instr_reg_2_valid,
    input  cpu_ctrl_pkg::reg_idx_t instr_reg_1_idx,
    input  cpu_ctrl_pkg::reg_idx_t instr_reg_2_idx,
    input  cpu_ctrl_pkg::reg_idx_t instr_dest_idx,
    input  logic                   instr_reg_write,
    input  logic                   instr_mem_read,
    input  logic                   instr_branch,
    input  logic                   instr_input_req,
    input  logic                   uart_complete,
    input  logic                   cpu_pause,
    input  logic                   input_complete,
    output cpu_ctrl_pkg::pc_t      pc,
    output logic                   uart_disable,
    output cpu_ctrl_pkg::issue_t   issue_type,
    output logic                   retire_valid,
    output cpu_ctrl_pkg::reg_idx_t retire_dest,
    output logic [15:0]            retired_count
);
    import cpu_ctrl_pkg::*;

    stage_ctrl_t if_ctrl, id_ctrl, ex_ctrl, mem_ctrl, wb_ctrl;
    logic        pc_reset, pc_overflow;

    // ID stage, from the IF/ID register
    logic     id_reg_1_valid, id_reg_2_valid, id_reg_write, id_mem_read;
    logic     id_branch, id_input_req, id_no_op;
    reg_idx_t id_reg_1_idx, id_reg_2_idx, id_dest_idx;

    // EX, MEM and WB stages
    reg_idx_t ex_dest_idx, mem_dest_idx, wb_dest_idx;
    logic     ex_reg_write, ex_mem_read, ex_input_req, ex_no_op;
    logic     mem_reg_write, mem_mem_read, mem_input_req, mem_no_op;
    logic     wb_no_op;

    fetch_unit u_fetch (.*);

    stage_reg id_ex (
        .clk, .rst_n, .ctrl(ex_ctrl),
        .in_dest(id_dest_idx), .in_reg_write(id_reg_write), .in_mem_read(id_mem_read),
        .in_input_req(id_input_req), .in_no_op(id_no_op),
        .out_dest(ex_dest_idx), .out_reg_write(ex_reg_write), .out_mem_read(ex_mem_read),
        .out_input_req(ex_input_req), .out_no_op(ex_no_op)
    );

    stage_reg ex_mem (
        .clk, .rst_n, .ctrl(mem_ctrl),
        .in_dest(ex_dest_idx), .in_reg_write(ex_reg_write), .in_mem_read(ex_mem_read),
        .in_input_req(ex_input_req), .in_no_op(ex_no_op),
        .out_dest(mem_dest_idx), .out_reg_write(mem_reg_write), .out_mem_read(mem_mem_read),
        .out_input_req(mem_input_req), .out_no_op(mem_no_op)
    );

    stage_reg mem_wb (
        .clk, .rst_n, .ctrl(wb_ctrl),
        .in_dest(mem_dest_idx), .in_reg_write(mem_reg_write), .in_mem_read(mem_mem_read),
        .in_input_req(mem_input_req), .in_no_op(mem_no_op),
        .out_dest(wb_dest_idx), .out_reg_write(), .out_mem_read(),
        .out_input_req(), .out_no_op(wb_no_op)            // enables end here without a register file
    );

    hazard_unit u_hazard (.*);

    retire_unit u_retire (.*);

endmodule

/* tests/hazard_chk.sv */
`timescale 1ns/10ps

module hazard_chk (
    input logic                      clk,
    input logic                      rst_n,
    input logic                      uart_disable,
    input logic                      pc_reset,
    input cpu_ctrl_pkg::stage_ctrl_t if_ctrl,
    input cpu_ctrl_pkg::stage_ctrl_t id_ctrl,
    input cpu_ctrl_pkg::stage_ctrl_t ex_ctrl,
    input cpu_ctrl_pkg::stage_ctrl_t mem_ctrl,
    input cpu_ctrl_pkg::stage_ctrl_t wb_ctrl,
    input cpu_ctrl_pkg::issue_t      issue_type
);
    import cpu_ctrl_pkg::*;

    logic all_normal;                                         // every stage advancing

    assign all_normal = (if_ctrl == NORMAL) && (id_ctrl == NORMAL) && (ex_ctrl == NORMAL) &&
                        (mem_ctrl == NORMAL) && (wb_ctrl == NORMAL);

    // hazard outputs move on the falling edge, so the rising edge sees them settled
    uart_open_only_when_stopped: assert property (@(posedge clk) disable iff (!rst_n)
        !uart_disable |-> (issue_type == UART || issue_type == PAUSE))
        else $error("uart_disable low while issue_type is %0d", issue_type);

    pc_reset_one_cycle: assert property (@(posedge clk) disable iff (!rst_n)
        pc_reset |=> !pc_reset)
        else $error("pc_reset held longer than one cycle");

    free_run_all_normal: assert property (@(posedge clk) disable iff (!rst_n)
        (issue_type == NONE) |-> all_normal)
        else $error("a stage command is not NORMAL with no issue pending");

endmodule

/* tests/pipeline_ctrl_tb.sv */
`timescale 1ns/10ps

module pipeline_ctrl_tb;
    import cpu_ctrl_pkg::*;

    localparam int CLK_PERIOD     = 100;                      // ns
    localparam int PROG_LEN       = int'(PC_MAX_VALUE) + 1;
    localparam int RUNS           = 4;                        // program passes in the test
    localparam int CYCLES_PER_RUN = 1000;                     // generous bound for one pass
    localparam int TIMEOUT_CYCLES = RUNS * CYCLES_PER_RUN;

    logic        clk = 1'b0;
    logic        rst_n;
    logic        instr_reg_1_valid, instr_reg_2_valid;
    reg_idx_t    instr_reg_1_idx, instr_reg_2_idx, instr_dest_idx;
    logic        instr_reg_write, instr_mem_read, instr_branch, instr_input_req;
    logic        uart_complete, cpu_pause, input_complete;
    pc_t         pc;
    logic        uart_disable;
    issue_t      issue_type;
    logic        retire_valid;
    reg_idx_t    retire_dest;
    logic [15:0] retired_count;

    reg_idx_t    prog_dest  [PROG_LEN];                       // program table, one row per address
    reg_idx_t    prog_src1  [PROG_LEN];                       // source 0 means unused
    reg_idx_t    prog_src2  [PROG_LEN];
    logic [3:0]  prog_flags [PROG_LEN];                       // {input_req, branch, mem_read, reg_write}

    int          errors = 0;
    int          checks = 0;
    int          keypads = 0;                                 // keypad stops served
    bit          data_seen = 0;
    int          run_idx = 0;                                 // position in program order
    int          last_run_len = 0;                            // retirements before the last restart
    int          retire_total = 0;                            // retire pulses seen since reset
    int          restarts = 0;
    pc_t         prev_pc = '0;
    integer      seed = 32'h5d6e;
    int          pause_delay;

    pipeline_ctrl_top uut (.*);

    bind hazard_unit hazard_chk u_hazard_chk (
        .clk, .rst_n, .uart_disable, .pc_reset, .if_ctrl, .id_ctrl,
        .ex_ctrl, .mem_ctrl, .wb_ctrl, .issue_type
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    task automatic check_equal(input string what, input logic [31:0] got,
                               input logic [31:0] expected);
        checks++;
        if (got !== expected) begin
            errors++;
            $display("mismatch at %0t: %s is %0d, expected %0d", $time, what, got, expected);
        end
    endtask

    task automatic set_instr(input int addr, input int dest, input int src1, input int src2,
                             input logic [3:0] flags);
        prog_dest[addr]  = reg_idx_t'(dest);
        prog_src1[addr]  = reg_idx_t'(src1);
        prog_src2[addr]  = reg_idx_t'(src2);
        prog_flags[addr] = flags;
    endtask

    task automatic load_program();
        set_instr(0, 1, 0, 0, 4'b0001);                       // r1 = imm
        set_instr(1, 2, 1, 0, 4'b0011);                       // load r2
        set_instr(2, 3, 2, 0, 4'b0001);                       // uses r2 right after the load
        set_instr(3, 4, 3, 0, 4'b0001);
        set_instr(4, 5, 4, 0, 4'b0100);                       // branch on r4 while it is in EX
        set_instr(5, 6, 0, 0, 4'b1001);                       // waits for keypad input
        set_instr(6, 7, 0, 0, 4'b0001);
        set_instr(7, 8, 0, 0, 4'b0011);                       // load r8
        set_instr(8, 9, 8, 6, 4'b0001);                       // load-use on r8
        set_instr(9, 10, 0, 0, 4'b0001);
        set_instr(10, 11, 0, 0, 4'b0001);
        set_instr(11, 12, 0, 0, 4'b0011);                     // load r12
        set_instr(12, 13, 12, 0, 4'b0100);                    // branch on the loaded value
        set_instr(13, 14, 0, 0, 4'b0001);
        set_instr(14, 15, 0, 0, 4'b0001);                     // tail kept free of hazards
        set_instr(15, 16, 0, 0, 4'b0001);
    endtask

    // instruction memory model, anything past the program reads as empty
    task automatic drive_fetch_pins(input pc_t addr);
        logic       in_range;
        logic [3:0] i;
        in_range = (addr <= PC_MAX_VALUE);
        i        = addr[3:0];
        instr_reg_1_idx   = prog_src1[i];
        instr_reg_2_idx   = prog_src2[i];
        instr_dest_idx    = prog_dest[i];
        instr_reg_1_valid = in_range && prog_src1[i] != '0;
        instr_reg_2_valid = in_range && prog_src2[i] != '0;
        {instr_input_req, instr_branch, instr_mem_read, instr_reg_write} =
            in_range ? prog_flags[i] : 4'b0000;
    endtask

    // program order from address 0, the order retirement must follow
    function automatic reg_idx_t expected_dest(input int k);
        return prog_dest[k];
    endfunction

    task automatic next_cycle();
        @(posedge clk);
        #1;                                                   // drive and sample clear of both edges
    endtask

    task automatic serve_keypad();
        logic [15:0] held;
        held = retired_count;
        repeat (4) next_cycle();
        check_equal("retired_count under keypad", 32'(retired_count), 32'(held));
        check_equal("issue_type under keypad", 32'(issue_type), 32'(KEYPAD));
        input_complete = 1'b1;
        next_cycle();
        input_complete = 1'b0;
        keypads++;
    endtask

    task automatic service_cycle();
        next_cycle();
        if (issue_type == DATA) data_seen = 1'b1;
        if (issue_type == KEYPAD) serve_keypad();
    endtask

    task automatic advance(input int n);
        repeat (n) service_cycle();
    endtask

    task automatic run_until(input issue_t want);
        do service_cycle(); while (issue_type != want);
    endtask

    task automatic pulse_uart_complete();
        uart_complete = 1'b1;
        next_cycle();
        uart_complete = 1'b0;
    endtask

    task automatic resume_program(input int run, input bit full_run);
        pulse_uart_complete();
        check_equal("issue_type after resume", 32'(issue_type), 32'(NONE));
        check_equal("uart_disable after resume", 32'(uart_disable), 32'd1);
        check_equal("pc after resume", pc, 32'd0);
        next_cycle();                                         // compare process sees the restart
        check_equal("restart count", 32'(restarts), 32'(run));
        if (full_run) check_equal("retired before restart", 32'(last_run_len), 32'(PROG_LEN));
    endtask

    initial begin
        load_program();
        drive_fetch_pins(pc_t'(PROG_LEN));                    // start with an empty fetch
        forever begin
            next_cycle();
            drive_fetch_pins(pc);
        end
    end

    initial begin
        forever begin
            @(negedge clk);                                   // retire outputs settled
            if (rst_n === 1'b1) begin
                if (pc == '0 && prev_pc != '0) begin          // program restarted at 0
                    last_run_len = run_idx;
                    run_idx      = 0;
                    restarts++;
                end
                prev_pc = pc;
                if (retire_valid === 1'b1) begin
                    retire_total++;
                    if (run_idx >= PROG_LEN) begin
                        errors++;
                        $display("an instruction retired past the end of the program at %0t",
                                 $time);
                    end else begin
                        check_equal("retire_dest", 32'(retire_dest), 32'(expected_dest(run_idx)));
                    end
                    run_idx++;
                end
                check_equal("retired_count", 32'(retired_count), 32'(retire_total));
            end
        end
    end

    initial begin
        #(TIMEOUT_CYCLES * CLK_PERIOD);
        $display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("Some tests failed");
        $finish;
    end

    initial begin
        rst_n          = 1'b0;
        cpu_pause      = 1'b0;
        uart_complete  = 1'b0;
        input_complete = 1'b0;
        repeat (8) @(posedge clk);
        #1;
        check_equal("uart_disable after reset", 32'(uart_disable), 32'd1);
        check_equal("issue_type after reset", 32'(issue_type), 32'(NONE));
        check_equal("pc after reset", pc, 32'd0);
        check_equal("retire_valid after reset", 32'(retire_valid), 32'd0);
        check_equal("retired_count after reset", 32'(retired_count), 32'd0);
        rst_n = 1'b1;

        run_until(UART);                                      // first pass runs off the end
        check_equal("uart_disable under uart", 32'(uart_disable), 32'd0);
        advance(8);                                           // in-flight work drains
        begin : frozen_check
            logic [15:0] held;
            held = retired_count;
            advance(4);
            check_equal("retired_count under uart", 32'(retired_count), 32'(held));
        end
        resume_program(1, 1'b1);

        pause_delay = 2 + ($unsigned($random(seed)) % 10);    // pause somewhere mid-program
        advance(pause_delay);
        cpu_pause = 1'b1;
        run_until(PAUSE);
        check_equal("uart_disable under pause", 32'(uart_disable), 32'd0);
        advance(8);
        pulse_uart_complete();                                // pause still high, must stay stopped
        check_equal("issue_type with pause high", 32'(issue_type), 32'(PAUSE));
        cpu_pause = 1'b0;
        advance(2);
        check_equal("issue_type before rewrite done", 32'(issue_type), 32'(PAUSE));
        resume_program(2, 1'b0);

        run_until(UART);                                      // pause arriving during uart
        cpu_pause = 1'b1;
        run_until(PAUSE);
        check_equal("uart_disable under pause", 32'(uart_disable), 32'd0);
        advance(8);
        pulse_uart_complete();
        check_equal("issue_type with pause high", 32'(issue_type), 32'(PAUSE));
        cpu_pause = 1'b0;
        advance(2);
        resume_program(3, 1'b1);
        advance(30);                                          // part of a fourth pass

        if (!data_seen) begin
            errors++;
            $display("no data hazard stop was ever shown on issue_type");
        end
        if (keypads < 2) begin
            errors++;
            $display("the keypad request stopped the pipeline only %0d times", keypads);
        end
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

/* tb.f */
rtl/cpu_ctrl_pkg.sv
rtl/fetch_unit.sv
rtl/stage_reg.sv
rtl/hazard_unit.sv
rtl/retire_unit.sv
rtl/pipeline_ctrl_top.sv
tests/hazard_chk.sv
tests/pipeline_ctrl_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= pipeline_ctrl_tb
FILELIST  ?= tb.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) | awk '{ print } /All tests passed/ { ok = 1 } END { exit !ok }'

clean:
	rm -rf $(OBJ_DIR)
